// File: common/execPkg.sv
`default_nettype none

package execPkg;

    typedef logic [31:0] Data;
    typedef logic [31:0] Addr;
    typedef logic [3:0]  Tag;

    // Encodings count up from zero in this order.
    typedef enum logic [4:0] {
        opLui,
        opAuipc,
        opBeq,
        opBne,
        opBlt,
        opBltu,
        opBge,
        opBgeu,
        opJal,
        opJalr,
        opAddi,
        opSlli,
        opSlti,
        opSltiu,
        opXori,
        opSrli,
        opSrai,
        opOri,
        opAndi,
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd
    } AluOp;

    typedef struct packed {
        logic ready;  // Value valid, otherwise waiting on tag.
        Tag   tag;
        Data  value;
    } SrcOperand;

    typedef struct packed {
        AluOp      op;
        Addr       pc;
        Data       imm;  // Already sign-extended.
        Tag        dest;
        SrcOperand src1;
        SrcOperand src2;
    } DispatchReq;

    typedef struct packed {
        AluOp op;
        Addr  pc;
        Data  imm;
        Tag   dest;
        Data  rs1;
        Data  rs2;
    } IssueReq;

    typedef struct packed {
        Tag  tag;
        Data data;
    } Wakeup;

    typedef struct packed {
        Tag   tag;
        Data  data;
        logic taken;
        Addr  nextPc;  // Resolved target for the reorder buffer.
    } ExecResult;

endpackage

`default_nettype wire

// File: hw/resStation/resStation.sv
`default_nettype none

module resStation #(
    parameter int rsDepth = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               dispatchValid,
    input  execPkg::DispatchReq dispatch,
    input  logic               extWakeValid,
    input  execPkg::Wakeup     extWake,
    input  logic               resWakeValid,
    input  execPkg::Wakeup     resWake,
    output logic               full,
    output logic               issueValid,
    output execPkg::IssueReq   issue
);
    import execPkg::*;

    localparam int idxWidth = (rsDepth > 1) ? $clog2(rsDepth) : 1;

    logic [rsDepth-1:0]  slotValid;
    DispatchReq          entries [rsDepth];

    logic [rsDepth-1:0]  readyVec;
    logic [idxWidth-1:0] freeIdx;
    logic                freeFound;
    logic [idxWidth-1:0] issueIdx;
    logic                anyReady;
    logic                dispatchWrite;
    DispatchReq          newEntry;

    // Capture a matching broadcast from either producer.
    function automatic SrcOperand wakeOperand(SrcOperand src);
        SrcOperand woken;
        woken = src;
        if (!src.ready) begin
            if (extWakeValid && extWake.tag == src.tag) begin
                woken.ready = 1'b1;
                woken.value = extWake.data;
            end else if (resWakeValid && resWake.tag == src.tag) begin
                woken.ready = 1'b1;
                woken.value = resWake.data;
            end
        end
        return woken;
    endfunction

    always_comb begin
        for (int i = 0; i < rsDepth; i++) begin
            readyVec[i] = slotValid[i] && entries[i].src1.ready && entries[i].src2.ready;
        end
    end

    // Lowest free slot and lowest ready slot.
    always_comb begin
        freeIdx   = '0;
        freeFound = 1'b0;
        issueIdx  = '0;
        anyReady  = 1'b0;
        for (int i = 0; i < rsDepth; i++) begin
            if (!slotValid[i] && !freeFound) begin
                freeIdx   = idxWidth'(i);
                freeFound = 1'b1;
            end
            if (readyVec[i] && !anyReady) begin
                issueIdx = idxWidth'(i);
                anyReady = 1'b1;
            end
        end
    end

    assign full          = ~freeFound;  // An issuing slot still counts as occupied.
    assign dispatchWrite = dispatchValid && !full;

    always_comb begin
        newEntry      = dispatch;
        newEntry.src1 = wakeOperand(dispatch.src1);
        newEntry.src2 = wakeOperand(dispatch.src2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid  <= '0;
            issueValid <= 1'b0;
        end else if (rdy) begin
            issueValid <= anyReady;
            for (int i = 0; i < rsDepth; i++) begin
                if (anyReady && issueIdx == idxWidth'(i)) begin
                    slotValid[i] <= 1'b0;
                end else if (dispatchWrite && freeIdx == idxWidth'(i)) begin
                    slotValid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (anyReady) begin
                issue <= '{
                    op:   entries[issueIdx].op,
                    pc:   entries[issueIdx].pc,
                    imm:  entries[issueIdx].imm,
                    dest: entries[issueIdx].dest,
                    rs1:  entries[issueIdx].src1.value,
                    rs2:  entries[issueIdx].src2.value
                };
            end
            for (int i = 0; i < rsDepth; i++) begin
                if (dispatchWrite && freeIdx == idxWidth'(i)) begin
                    entries[i] <= newEntry;
                end else begin
                    entries[i].src1 <= wakeOperand(entries[i].src1);
                    entries[i].src2 <= wakeOperand(entries[i].src2);
                end
            end
        end
    end

    // Dispatcher must watch full.
    assert property (@(posedge clk) disable iff (rst)
        rdy && dispatchValid |-> !full);

    assert property (@(posedge clk) disable iff (rst)
        !$isunknown(issueValid));

    // Renaming hands out unique tags for in-flight ops.
    for (genvar a = 0; a < rsDepth; a++) begin : gTagA
        for (genvar b = a + 1; b < rsDepth; b++) begin : gTagB
            assert property (@(posedge clk) disable iff (rst)
                !(slotValid[a] && slotValid[b] && entries[a].dest == entries[b].dest));
        end
    end

endmodule

`default_nettype wire

// File: hw/aluExecute.sv
`default_nettype none

module aluExecute (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                issueValid,
    input  execPkg::IssueReq    issue,
    output logic                resultValid,
    output execPkg::ExecResult  result
);
    import execPkg::*;

    Data  aluData;
    logic taken;
    Addr  nextPc;
    Addr  seqPc;
    Addr  branchTarget;
    Addr  jalrTarget;

    assign seqPc        = issue.pc + 32'd4;
    assign branchTarget = issue.pc + issue.imm;
    assign jalrTarget   = (issue.rs1 + issue.imm) & ~32'd1;

    always_comb begin
        aluData = '0;
        taken   = 1'b0;
        case (issue.op)
            opLui:   aluData = issue.imm;
            opAuipc: aluData = issue.pc + issue.imm;

            opBeq:   taken = issue.rs1 == issue.rs2;
            opBne:   taken = issue.rs1 != issue.rs2;
            opBlt:   taken = $signed(issue.rs1) < $signed(issue.rs2);
            opBltu:  taken = issue.rs1 < issue.rs2;
            opBge:   taken = $signed(issue.rs1) >= $signed(issue.rs2);
            opBgeu:  taken = issue.rs1 >= issue.rs2;

            opJal, opJalr: begin
                aluData = seqPc;  // Link address.
                taken   = 1'b1;
            end

            opAddi:  aluData = issue.rs1 + issue.imm;
            opSlli:  aluData = issue.rs1 << issue.imm[4:0];
            opSlti:  aluData = {31'd0, $signed(issue.rs1) < $signed(issue.imm)};
            opSltiu: aluData = {31'd0, issue.rs1 < issue.imm};
            opXori:  aluData = issue.rs1 ^ issue.imm;
            opSrli:  aluData = issue.rs1 >> issue.imm[4:0];
            opSrai:  aluData = Data'($signed(issue.rs1) >>> issue.imm[4:0]);
            opOri:   aluData = issue.rs1 | issue.imm;
            opAndi:  aluData = issue.rs1 & issue.imm;

            opAdd:   aluData = issue.rs1 + issue.rs2;
            opSub:   aluData = issue.rs1 - issue.rs2;
            opSll:   aluData = issue.rs1 << issue.rs2[4:0];
            opSlt:   aluData = {31'd0, $signed(issue.rs1) < $signed(issue.rs2)};
            opSltu:  aluData = {31'd0, issue.rs1 < issue.rs2};
            opXor:   aluData = issue.rs1 ^ issue.rs2;
            opSrl:   aluData = issue.rs1 >> issue.rs2[4:0];
            opSra:   aluData = Data'($signed(issue.rs1) >>> issue.rs2[4:0]);
            opOr:    aluData = issue.rs1 | issue.rs2;
            opAnd:   aluData = issue.rs1 & issue.rs2;

            default: aluData = '0;
        endcase
    end

    // Not taken falls through to the next instruction.
    always_comb begin
        if (!taken) begin
            nextPc = seqPc;
        end else if (issue.op == opJalr) begin
            nextPc = jalrTarget;
        end else begin
            nextPc = branchTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else if (rdy) begin
            resultValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueValid) begin
            result <= '{
                tag:    issue.dest,
                data:   aluData,
                taken:  taken,
                nextPc: nextPc
            };
        end
    end

    // Each result traces back to an issue on the previous enabled edge.
    assert property (@(posedge clk) disable iff (rst)
        $rose(resultValid) |-> $past(issueValid) && $past(rdy));

endmodule

`default_nettype wire

// File: hw/aluCluster.sv
`default_nettype none

module aluCluster #(
    parameter int rsDepth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                dispatchValid,
    input  execPkg::DispatchReq dispatch,
    input  logic                extWakeValid,
    input  execPkg::Wakeup      extWake,
    output logic                full,
    output logic                resultValid,
    output execPkg::ExecResult  result
);
    import execPkg::*;

    logic    issueValid;
    IssueReq issue;
    Wakeup   resWake;

    // Own results wake dependents in the station.
    assign resWake = '{tag: result.tag, data: result.data};

    resStation #(
        .rsDepth(rsDepth)
    ) i_resStation (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .dispatchValid(dispatchValid),
        .dispatch     (dispatch),
        .extWakeValid (extWakeValid),
        .extWake      (extWake),
        .resWakeValid (resultValid),
        .resWake      (resWake),
        .full         (full),
        .issueValid   (issueValid),
        .issue        (issue)
    );

    aluExecute i_aluExecute (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issueValid (issueValid),
        .issue      (issue),
        .resultValid(resultValid),
        .result     (result)
    );

endmodule

`default_nettype wire

// File: tb/aluCheckTasks.svh
`ifndef ALU_CHECK_TASKS_SVH
`define ALU_CHECK_TASKS_SVH

// A result tag must belong to an instruction still in flight.
task automatic checkTagOutstanding(execPkg::Tag tag, int issued, int done);
    if (issued == done) begin
        stopWithFailure($sformatf("result tag %0d was not expected or was already seen", tag));
    end
endtask

task automatic compareResult(execPkg::ExecResult got, execPkg::ExecResult exp);
    if (got.data !== exp.data) begin
        stopWithFailure($sformatf("tag %0d data %08h, expected %08h",
                                  got.tag, got.data, exp.data));
    end
    if (got.taken !== exp.taken) begin
        stopWithFailure($sformatf("tag %0d taken %0b, expected %0b",
                                  got.tag, got.taken, exp.taken));
    end
    if (got.nextPc !== exp.nextPc) begin
        stopWithFailure($sformatf("tag %0d next pc %08h, expected %08h",
                                  got.tag, got.nextPc, exp.nextPc));
    end
endtask

`endif

// File: tb/aluClusterTb.sv
`default_nettype none

module aluClusterTb;
    timeunit 1ns;
    timeprecision 1ps;
    import execPkg::*;

    localparam int rsDepth   = 4;
    localparam int caseWords = 11;  // Words per line of the case file.
    localparam int maxCases  = 64;

    logic       clk;
    logic       rst;
    logic       rdy;
    logic       dispatchValid;
    DispatchReq dispatch;
    logic       extWakeValid;
    Wakeup      extWake;
    logic       full;
    logic       resultValid;
    ExecResult  result;

    logic [31:0] caseMem [0:caseWords*maxCases];
    ExecResult   expected [16];
    int          tagIssued [16];  // Dispatches per tag.
    int          tagDone [16];    // Results per tag.
    int          numCases;
    int          resultsSeen;
    int          cycleCount;
    int          timeoutLimit;
    logic        sawFull;
    logic [31:0] gapRand;
    logic [31:0] rdyRand;
    Wakeup       wakeQueue [$];

    aluCluster #(
        .rsDepth(rsDepth)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .dispatchValid(dispatchValid),
        .dispatch     (dispatch),
        .extWakeValid (extWakeValid),
        .extWake      (extWake),
        .full         (full),
        .resultValid  (resultValid),
        .result       (result)
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stopWithFailure(string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "first error reached");
    endtask

    `include "aluCheckTasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random stall cycles once reset is released.
    initial begin
        rdy <= 1'b1;
        rdyRand = xorshift(32'h3a4b);
        wait (rst === 1'b0);
        forever begin
            @(posedge clk);
            rdyRand = xorshift(rdyRand);
            rdy <= (rdyRand[1:0] != 2'd0);
        end
    end

    // Holds until an enabled edge has taken the driven inputs.
    task automatic waitAccept();
        do @(posedge clk); while (!rdy);
    endtask

    task automatic flushWakes();
        Wakeup wk;
        while (wakeQueue.size() > 0) begin
            wk = wakeQueue.pop_front();
            extWakeValid <= 1'b1;
            extWake      <= wk;
            waitAccept();
        end
        extWakeValid <= 1'b0;
    endtask

    task automatic runCase(int n);
        logic [31:0] w [caseWords];
        DispatchReq  req;
        int          gap;
        for (int k = 0; k < caseWords; k++) begin
            w[k] = caseMem[1 + n*caseWords + k];
        end
        if (w[7] != 32'd1) begin
            flushWakes();
        end
        if (w[7] == 32'd0) begin
            gapRand = xorshift(gapRand);
            gap = int'(gapRand % 32'd3);
            repeat (gap) @(posedge clk);
        end
        do @(posedge clk); while (full || tagIssued[w[3][3:0]] != tagDone[w[3][3:0]]);
        req.op   = AluOp'(w[0][4:0]);
        req.pc   = w[1];
        req.imm  = w[2];
        req.dest = w[3][3:0];
        req.src1 = '{ready: (w[7] == 32'd0), tag: w[4][3:0],
                     value: (w[7] == 32'd0) ? w[5] : 32'd0};
        req.src2 = '{ready: 1'b1, tag: 4'd0, value: w[6]};
        expected[req.dest] = '{tag: req.dest, data: w[8], taken: w[9][0], nextPc: w[10]};
        tagIssued[req.dest] = tagIssued[req.dest] + 1;
        dispatchValid <= 1'b1;
        dispatch      <= req;
        if (w[7] == 32'd2) begin  // Broadcast lands with the dispatch.
            extWakeValid <= 1'b1;
            extWake      <= '{tag: w[4][3:0], data: w[5]};
        end
        waitAccept();
        dispatchValid <= 1'b0;
        extWakeValid  <= 1'b0;
        if (w[7] == 32'd1) begin
            wakeQueue.push_back(Wakeup'{tag: w[4][3:0], data: w[5]});
            if (wakeQueue.size() >= rsDepth) begin
                flushWakes();
            end
        end
    endtask

    initial begin
        rst           <= 1'b1;
        dispatchValid <= 1'b0;
        dispatch      <= '0;
        extWakeValid  <= 1'b0;
        extWake       <= '0;
        gapRand = 32'h3a4b;
        for (int t = 0; t < 16; t++) begin
            tagIssued[t] = 0;
        end
        $readmemh("tb/aluCases.mem", caseMem);
        numCases     = int'(caseMem[0]);
        timeoutLimit = numCases*20 + 200;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < numCases; n++) begin
            runCase(n);
        end
        flushWakes();
        wait (resultsSeen == numCases);
        if (!sawFull) begin
            $display("Station never reported full during the run");
            $display("TESTBENCH FAILED");
            $fatal(1, "full not observed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    // One scoreboard check per enabled edge that consumes a result.
    always @(posedge clk) begin
        if (rst) begin
            sawFull     <= 1'b0;
            resultsSeen <= 0;
            for (int t = 0; t < 16; t++) begin
                tagDone[t] <= 0;
            end
        end else begin
            if (full) begin
                sawFull <= 1'b1;
            end
            if (rdy && resultValid) begin
                checkTagOutstanding(result.tag, tagIssued[result.tag], tagDone[result.tag]);
                compareResult(result, expected[result.tag]);
                tagDone[result.tag] <= tagDone[result.tag] + 1;
                resultsSeen         <= resultsSeen + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycleCount <= 0;
        end else begin
            cycleCount <= cycleCount + 1;
            if (cycleCount >= timeoutLimit) begin
                $display("Timeout after %0d cycles with %0d of %0d results seen",
                         cycleCount, resultsSeen, numCases);
                $display("TESTBENCH FAILED");
                $fatal(1, "timeout");
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/aluCases.mem
// First word: number of cases. Then one case per line:
// op pc imm dest waitTag src1 src2 mode(0 ready,1 ext later,2 ext same cycle,3 chain) data taken nextPc
0000002e
00 00001000 12345000 0 0 00000000 00000000 0 12345000 0 00001004
01 00001004 fffff000 1 0 00000000 00000000 0 00000004 0 00001008
0a 00001008 ffffffff 2 0 00000005 00000000 0 00000004 0 0000100c
0b 0000100c 0000001f 3 0 00000003 00000000 0 80000000 0 00001010
0b 00001010 00000021 4 0 00000003 00000000 0 00000006 0 00001014
0c 00001014 00000001 5 0 ffffffff 00000000 0 00000001 0 00001018
0d 00001018 00000001 6 0 ffffffff 00000000 0 00000000 0 0000101c
0e 0000101c ffffffff 7 0 0f0f0f0f 00000000 0 f0f0f0f0 0 00001020
0f 00001020 0000001f 8 0 80000000 00000000 0 00000001 0 00001024
10 00001024 0000001f 9 0 80000000 00000000 0 ffffffff 0 00001028
11 00001028 000000f0 0 0 0000000f 00000000 0 000000ff 0 0000102c
12 0000102c 0000fff0 1 0 12345678 00000000 0 00005670 0 00001030
13 00001030 00000000 2 0 7fffffff 00000001 0 80000000 0 00001034
14 00001034 00000000 3 0 00000000 00000001 0 ffffffff 0 00001038
15 00001038 00000000 4 0 00000001 00000024 0 00000010 0 0000103c
16 0000103c 00000000 5 0 80000000 00000001 0 00000001 0 00001040
17 00001040 00000000 6 0 80000000 00000001 0 00000000 0 00001044
18 00001044 00000000 7 0 aaaaaaaa ffffffff 0 55555555 0 00001048
19 00001048 00000000 8 0 80000000 0000003f 0 00000001 0 0000104c
1a 0000104c 00000000 9 0 80000000 00000004 0 f8000000 0 00001050
1b 00001050 00000000 0 0 f0000000 0000000f 0 f000000f 0 00001054
1c 00001054 00000000 1 0 ff00ff00 0ff00ff0 0 0f000f00 0 00001058
02 00002000 00000040 2 0 00000005 00000005 0 00000000 1 00002040
02 00002004 00000040 3 0 00000005 00000006 0 00000000 0 00002008
03 00002008 fffffff0 4 0 00000005 00000006 0 00000000 1 00001ff8
03 0000200c 00000040 5 0 00000007 00000007 0 00000000 0 00002010
04 00002010 00000040 6 0 ffffffff 00000001 0 00000000 1 00002050
04 00002014 00000040 7 0 00000001 ffffffff 0 00000000 0 00002018
05 00002018 00000040 8 0 ffffffff 00000001 0 00000000 0 0000201c
05 0000201c 00000040 9 0 00000001 ffffffff 0 00000000 1 0000205c
06 00002020 00000040 0 0 00000003 00000003 0 00000000 1 00002060
06 00002024 00000040 1 0 80000000 00000000 0 00000000 0 00002028
07 00002028 00000040 2 0 80000000 00000000 0 00000000 1 00002068
07 0000202c 00000040 3 0 00000000 00000001 0 00000000 0 00002030
08 00003000 fffff800 4 0 00000000 00000000 0 00003004 1 00002800
09 00003004 00000005 5 0 00001000 00000000 0 00003008 1 00001004
0a 00004000 00000001 6 c 00000010 00000000 2 00000011 0 00004004
13 00004004 00000000 7 c 00000100 00000023 1 00000123 0 00004008
14 00004008 00000000 8 d 00000050 00000060 1 fffffff0 0 0000400c
05 0000400c 00000020 9 e 00000001 00000002 1 00000000 1 0000402c
09 00004010 00000004 0 f 00005003 00000000 1 00004014 1 00005006
0a 00005000 00000007 1 0 00000001 00000000 0 00000008 0 00005004
0b 00005004 00000002 2 1 00000000 00000000 3 00000020 0 00005008
13 00005008 00000000 3 2 00000000 00000005 3 00000025 0 0000500c
14 0000500c 00000000 4 3 00000000 00000025 3 00000000 0 00005010
02 00005010 00000100 5 4 00000000 00000000 3 00000000 1 00005110

// File: sim.f
+incdir+tb
common/execPkg.sv
hw/resStation/resStation.sv
hw/aluExecute.sv
hw/aluCluster.sv
tb/aluClusterTb.sv

// File: runSim.sh
#!/bin/sh
# Compile and run the ALU cluster testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module aluClusterTb \
    -f sim.f \
    -o aluClusterSim
./obj_dir/aluClusterSim
